// ==== common/pcie_cfg_consts.svh ====
`ifndef PCIE_CFG_CONSTS_SVH
`define PCIE_CFG_CONSTS_SVH

`define PCIE_ADDR_W      64
`define RAM_ADDR_W       32
`define DMA_LEN_W        16
`define DMA_TAG_W        32
`define AXIL_DATA_W      32
`define AXIL_ADDR_W      32
`define CSR_DEC_W        16

`define REG_FW_ID        16'h0000
`define REG_FW_VER       16'h0004
`define REG_BOARD_ID     16'h0008
`define REG_BOARD_VER    16'h000C
`define REG_FPGA_ID      16'h0040
`define REG_DMA_EN       16'h0400
`define REG_DMA_RD_BASE  16'h0440
`define REG_DMA_WR_BASE  16'h0460
`define REG_LOOPBACK     16'h0480

// Offsets inside a 32-byte channel window
`define OFS_PCIE_LO      5'h00
`define OFS_PCIE_HI      5'h04
`define OFS_RAM          5'h08
`define OFS_LEN          5'h10
`define OFS_TAG          5'h14
`define OFS_STATUS       5'h18

`define FW_ID_VAL        32'h0000_0000
`define FW_VER_VAL       32'h0000_0001
`define BOARD_ID_VAL     32'h1ce4_0003 // Vendor in upper half
`define BOARD_VER_VAL    32'h0000_0001
`define FPGA_ID_VAL      32'h0382_3093

`endif

// ==== common/pcie_cfg_pkg.sv ====
`include "pcie_cfg_consts.svh"

package pcie_cfg_pkg;

  typedef struct packed {
    logic [`PCIE_ADDR_W-1:0] pcie_addr;
    logic [`RAM_ADDR_W-1:0]  ram_addr;
    logic [`DMA_LEN_W-1:0]   len;
    logic [`DMA_TAG_W-1:0]   tag;
  } dma_desc_t;

  // Target register inside a descriptor channel
  typedef enum logic [2:0] {
    PCIE_LO = 3'd0,
    PCIE_HI = 3'd1,
    RAM     = 3'd2,
    LEN     = 3'd3,
    TAG     = 3'd4
  } desc_field_e;

  typedef struct packed {
    logic                    en;
    desc_field_e             field;
    logic [`AXIL_DATA_W-1:0] data;
  } chan_wr_t;

  typedef struct packed {
    logic [`DMA_TAG_W-1:0] status_tags;
  } chan_rd_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic                    wvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_t;

endpackage

// ==== dma_desc/dma_desc_channel.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_consts.svh"

module dma_desc_channel (
  input  logic                     pcie_clk,
  input  logic                     pcie_rst,
  input  pcie_cfg_pkg::chan_wr_t   chan_wr_i,
  input  logic                     status_clear_i,
  input  logic                     desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]    status_tag_i,
  input  logic                     status_valid_i,
  output pcie_cfg_pkg::dma_desc_t  desc_o,
  output logic                     desc_valid_o,
  output pcie_cfg_pkg::chan_rd_t   chan_rd_o
);

  logic                   tag_wr;
  logic [`DMA_TAG_W-1:0]  status_tags;

  // Writing the tag launches the descriptor
  assign tag_wr = chan_wr_i.en && (chan_wr_i.field == pcie_cfg_pkg::TAG);

  always_ff @(posedge pcie_clk) begin
    if (chan_wr_i.en) begin
      case (chan_wr_i.field)
        pcie_cfg_pkg::PCIE_LO: desc_o.pcie_addr[31:0] <= chan_wr_i.data;
        pcie_cfg_pkg::PCIE_HI: desc_o.pcie_addr[`PCIE_ADDR_W-1:32] <= chan_wr_i.data;
        pcie_cfg_pkg::RAM:     desc_o.ram_addr <= chan_wr_i.data[`RAM_ADDR_W-1:0];
        pcie_cfg_pkg::LEN:     desc_o.len <= chan_wr_i.data[`DMA_LEN_W-1:0];
        pcie_cfg_pkg::TAG:     desc_o.tag <= chan_wr_i.data[`DMA_TAG_W-1:0];
        default: ;
      endcase
    end
  end

  // Held until the engine takes it
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
    end else if (tag_wr) begin
      desc_valid_o <= 1'b1;
    end else if (desc_ready_i) begin
      desc_valid_o <= 1'b0;
    end
  end

  // Completion tags, cleared by a status read.
  // A tag arriving with the clear is kept for the next read.
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      status_tags <= '0;
    end else if (status_clear_i) begin
      status_tags <= status_valid_i ? status_tag_i : '0;
    end else if (status_valid_i) begin
      status_tags <= status_tags | status_tag_i;
    end
  end

  assign chan_rd_o = '{status_tags: status_tags};

endmodule

// ==== src/pcie_cfg_csr.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_consts.svh"

module pcie_cfg_csr (
  input  logic                      pcie_clk,
  input  logic                      pcie_rst,
  input  pcie_cfg_pkg::axil_req_t   axil_req_i,
  input  pcie_cfg_pkg::chan_rd_t    rd_chan_i,
  input  pcie_cfg_pkg::chan_rd_t    wr_chan_i,
  output logic                      awready_o,
  output logic                      wready_o,
  output logic                      bvalid_o,
  output logic                      arready_o,
  output logic                      rvalid_o,
  output logic [`AXIL_DATA_W-1:0]   rdata_o,
  output pcie_cfg_pkg::chan_wr_t    rd_wr_o,
  output pcie_cfg_pkg::chan_wr_t    wr_wr_o,
  output logic                      rd_status_clear_o,
  output logic                      wr_status_clear_o,
  output logic                      dma_enable_o,
  output logic                      loopback_o
);

  logic                       wr_accept;
  logic                       rd_accept;
  logic [`CSR_DEC_W-1:0]      waddr;
  logic [`CSR_DEC_W-1:0]      raddr;
  logic [`CSR_DEC_W-1:0]      wbase;
  logic                       field_hit;
  pcie_cfg_pkg::desc_field_e  field;
  logic [`AXIL_DATA_W-1:0]    rd_mux;

  assign wr_accept = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_o;
  assign rd_accept = axil_req_i.arvalid && !rvalid_o;

  assign waddr = {axil_req_i.awaddr[`CSR_DEC_W-1:2], 2'b00}; // Word aligned
  assign raddr = {axil_req_i.araddr[`CSR_DEC_W-1:2], 2'b00};
  assign wbase = {waddr[`CSR_DEC_W-1:5], 5'b00000};         // Channel window base

  // Field select from the offset inside the window
  always_comb begin
    field_hit = 1'b1;
    field     = pcie_cfg_pkg::PCIE_LO;
    case (waddr[4:0])
      `OFS_PCIE_LO: field = pcie_cfg_pkg::PCIE_LO;
      `OFS_PCIE_HI: field = pcie_cfg_pkg::PCIE_HI;
      `OFS_RAM:     field = pcie_cfg_pkg::RAM;
      `OFS_LEN:     field = pcie_cfg_pkg::LEN;
      `OFS_TAG:     field = pcie_cfg_pkg::TAG;
      default:      field_hit = 1'b0;
    endcase
  end

  assign rd_wr_o = '{
    en:    wr_accept && field_hit && (wbase == `REG_DMA_RD_BASE),
    field: field,
    data:  axil_req_i.wdata
  };
  assign wr_wr_o = '{
    en:    wr_accept && field_hit && (wbase == `REG_DMA_WR_BASE),
    field: field,
    data:  axil_req_i.wdata
  };

  // Sticky tags reload in the accept cycle
  assign rd_status_clear_o = rd_accept && (raddr == `REG_DMA_RD_BASE + `OFS_STATUS);
  assign wr_status_clear_o = rd_accept && (raddr == `REG_DMA_WR_BASE + `OFS_STATUS);

  always_comb begin
    rd_mux = '0; // Unmapped reads as zero
    case (raddr)
      `REG_FW_ID:                    rd_mux = `FW_ID_VAL;
      `REG_FW_VER:                   rd_mux = `FW_VER_VAL;
      `REG_BOARD_ID:                 rd_mux = `BOARD_ID_VAL;
      `REG_BOARD_VER:                rd_mux = `BOARD_VER_VAL;
      `REG_FPGA_ID:                  rd_mux = `FPGA_ID_VAL;
      `REG_DMA_EN:                   rd_mux = {{(`AXIL_DATA_W-1){1'b0}}, dma_enable_o};
      `REG_DMA_RD_BASE + `OFS_STATUS: rd_mux = rd_chan_i.status_tags;
      `REG_DMA_WR_BASE + `OFS_STATUS: rd_mux = wr_chan_i.status_tags;
      `REG_LOOPBACK:                 rd_mux = {{(`AXIL_DATA_W-1){1'b0}}, loopback_o};
      default:                       rd_mux = '0;
    endcase
  end

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      awready_o    <= 1'b0;
      wready_o     <= 1'b0;
      bvalid_o     <= 1'b0;
      arready_o    <= 1'b0;
      rvalid_o     <= 1'b0;
      dma_enable_o <= 1'b1;
      loopback_o   <= 1'b0;
    end else begin
      awready_o <= wr_accept; // One-cycle pulse
      wready_o  <= wr_accept;
      bvalid_o  <= wr_accept || (bvalid_o && !axil_req_i.bready);
      arready_o <= rd_accept;
      rvalid_o  <= rd_accept || (rvalid_o && !axil_req_i.rready);

      if (wr_accept && (waddr == `REG_DMA_EN)) begin
        dma_enable_o <= axil_req_i.wdata[0];
      end
      if (wr_accept && (waddr == `REG_LOOPBACK)) begin
        loopback_o <= axil_req_i.wdata[0];
      end
    end
  end

  // Data captured with the pre-clear status value
  always_ff @(posedge pcie_clk) begin
    if (rd_accept) begin
      rdata_o <= rd_mux;
    end
  end

endmodule

// ==== src/pcie_cfg_top.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_consts.svh"

module pcie_cfg_top (
  input  logic                     pcie_clk,
  input  logic                     pcie_rst,
  input  pcie_cfg_pkg::axil_req_t  axil_req_i,
  output logic                     awready_o,
  output logic                     wready_o,
  output logic                     bvalid_o,
  output logic                     arready_o,
  output logic                     rvalid_o,
  output logic [`AXIL_DATA_W-1:0]  rdata_o,
  output pcie_cfg_pkg::dma_desc_t  rd_desc_o,
  output logic                     rd_desc_valid_o,
  input  logic                     rd_desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]    rd_status_tag_i,
  input  logic                     rd_status_valid_i,
  output pcie_cfg_pkg::dma_desc_t  wr_desc_o,
  output logic                     wr_desc_valid_o,
  input  logic                     wr_desc_ready_i,
  input  logic [`DMA_TAG_W-1:0]    wr_status_tag_i,
  input  logic                     wr_status_valid_i,
  output logic                     dma_enable_o,
  output logic                     loopback_o
);

  pcie_cfg_pkg::chan_wr_t  rd_wr;
  pcie_cfg_pkg::chan_wr_t  wr_wr;
  pcie_cfg_pkg::chan_rd_t  rd_chan;
  pcie_cfg_pkg::chan_rd_t  wr_chan;
  logic                    rd_status_clear;
  logic                    wr_status_clear;

  pcie_cfg_csr u_csr (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .axil_req_i        (axil_req_i),
    .rd_chan_i         (rd_chan),
    .wr_chan_i         (wr_chan),
    .awready_o         (awready_o),
    .wready_o          (wready_o),
    .bvalid_o          (bvalid_o),
    .arready_o         (arready_o),
    .rvalid_o          (rvalid_o),
    .rdata_o           (rdata_o),
    .rd_wr_o           (rd_wr),
    .wr_wr_o           (wr_wr),
    .rd_status_clear_o (rd_status_clear),
    .wr_status_clear_o (wr_status_clear),
    .dma_enable_o      (dma_enable_o),
    .loopback_o        (loopback_o)
  );

  // Host to card
  dma_desc_channel u_rd_chan (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .chan_wr_i      (rd_wr),
    .status_clear_i (rd_status_clear),
    .desc_ready_i   (rd_desc_ready_i),
    .status_tag_i   (rd_status_tag_i),
    .status_valid_i (rd_status_valid_i),
    .desc_o         (rd_desc_o),
    .desc_valid_o   (rd_desc_valid_o),
    .chan_rd_o      (rd_chan)
  );

  // Card to host
  dma_desc_channel u_wr_chan (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .chan_wr_i      (wr_wr),
    .status_clear_i (wr_status_clear),
    .desc_ready_i   (wr_desc_ready_i),
    .status_tag_i   (wr_status_tag_i),
    .status_valid_i (wr_status_valid_i),
    .desc_o         (wr_desc_o),
    .desc_valid_o   (wr_desc_valid_o),
    .chan_rd_o      (wr_chan)
  );

endmodule

// ==== bench/pcie_cfg_props.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_consts.svh"

module pcie_cfg_props (
  input logic                     pcie_clk,
  input logic                     pcie_rst,
  input pcie_cfg_pkg::axil_req_t  axil_req_i,
  input logic                     awready_o,
  input logic                     wready_o,
  input logic                     bvalid_o,
  input logic                     arready_o,
  input logic                     rvalid_o,
  input logic [`AXIL_DATA_W-1:0]  rdata_o,
  input pcie_cfg_pkg::dma_desc_t  rd_desc_o,
  input logic                     rd_desc_valid_o,
  input logic                     rd_desc_ready_i,
  input pcie_cfg_pkg::dma_desc_t  wr_desc_o,
  input logic                     wr_desc_valid_o,
  input logic                     wr_desc_ready_i,
  input logic                     dma_enable_o,
  input logic                     loopback_o
);

  int unsigned fail_count = 0;

  bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    bvalid_o && !axil_req_i.bready |=> bvalid_o)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rvalid_o && !axil_req_i.rready |=> rvalid_o && $stable(rdata_o))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_count++;
    end

  awready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    awready_o |=> !awready_o)
    else begin
      $error("awready high for more than one cycle");
      fail_count++;
    end

  arready_pulse: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    arready_o |=> !arready_o)
    else begin
      $error("arready high for more than one cycle");
      fail_count++;
    end

  // Back-pressure on the descriptor outputs
  rd_desc_stable: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_desc_valid_o && !rd_desc_ready_i |=> rd_desc_valid_o && $stable(rd_desc_o))
    else begin
      $error("read channel descriptor changed while stalled");
      fail_count++;
    end

  wr_desc_stable: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_desc_valid_o && !wr_desc_ready_i |=> wr_desc_valid_o && $stable(wr_desc_o))
    else begin
      $error("write channel descriptor changed while stalled");
      fail_count++;
    end

  reset_state: assert property (@(posedge pcie_clk)
    $fell(pcie_rst) |-> !awready_o && !wready_o && !bvalid_o && !arready_o && !rvalid_o &&
      !rd_desc_valid_o && !wr_desc_valid_o && dma_enable_o && !loopback_o)
    else begin
      $error("outputs not in reset state after reset");
      fail_count++;
    end

endmodule

bind pcie_cfg_top pcie_cfg_props u_props (
  .pcie_clk        (pcie_clk),
  .pcie_rst        (pcie_rst),
  .axil_req_i      (axil_req_i),
  .awready_o       (awready_o),
  .wready_o        (wready_o),
  .bvalid_o        (bvalid_o),
  .arready_o       (arready_o),
  .rvalid_o        (rvalid_o),
  .rdata_o         (rdata_o),
  .rd_desc_o       (rd_desc_o),
  .rd_desc_valid_o (rd_desc_valid_o),
  .rd_desc_ready_i (rd_desc_ready_i),
  .wr_desc_o       (wr_desc_o),
  .wr_desc_valid_o (wr_desc_valid_o),
  .wr_desc_ready_i (wr_desc_ready_i),
  .dma_enable_o    (dma_enable_o),
  .loopback_o      (loopback_o)
);

// ==== bench/pcie_cfg_tb.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_consts.svh"

module pcie_cfg_tb;

  logic                     pcie_clk;
  logic                     pcie_rst;
  pcie_cfg_pkg::axil_req_t  axil_req;
  logic                     awready;
  logic                     wready;
  logic                     bvalid;
  logic                     arready;
  logic                     rvalid;
  logic [`AXIL_DATA_W-1:0]  rdata;
  pcie_cfg_pkg::dma_desc_t  rd_desc;
  pcie_cfg_pkg::dma_desc_t  wr_desc;
  logic                     rd_desc_valid;
  logic                     wr_desc_valid;
  logic                     rd_desc_ready;
  logic                     wr_desc_ready;
  logic [`DMA_TAG_W-1:0]    rd_status_tag;
  logic [`DMA_TAG_W-1:0]    wr_status_tag;
  logic                     rd_status_valid;
  logic                     wr_status_valid;
  logic                     dma_enable;
  logic                     loopback;
  int                       checks;
  int                       errors;
  int                       timeouts;

  pcie_cfg_top dut (
    .pcie_clk          (pcie_clk),
    .pcie_rst          (pcie_rst),
    .axil_req_i        (axil_req),
    .awready_o         (awready),
    .wready_o          (wready),
    .bvalid_o          (bvalid),
    .arready_o         (arready),
    .rvalid_o          (rvalid),
    .rdata_o           (rdata),
    .rd_desc_o         (rd_desc),
    .rd_desc_valid_o   (rd_desc_valid),
    .rd_desc_ready_i   (rd_desc_ready),
    .rd_status_tag_i   (rd_status_tag),
    .rd_status_valid_i (rd_status_valid),
    .wr_desc_o         (wr_desc),
    .wr_desc_valid_o   (wr_desc_valid),
    .wr_desc_ready_i   (wr_desc_ready),
    .wr_status_tag_i   (wr_status_tag),
    .wr_status_valid_i (wr_status_valid),
    .dma_enable_o      (dma_enable),
    .loopback_o        (loopback)
  );

  initial begin
    pcie_clk = 1'b0;
    forever #2 pcie_clk = ~pcie_clk;
  end

  task automatic report_timeout(input string what);
    timeouts++;
    $display("TIMEOUT: %s did not arrive within 50 cycles", what);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
    end
  endtask

  function automatic logic [`CSR_DEC_W-1:0] status_addr(input logic wr_side);
    return (wr_side ? `REG_DMA_WR_BASE : `REG_DMA_RD_BASE) + `OFS_STATUS;
  endfunction

  task automatic write_reg(input logic [`CSR_DEC_W-1:0] addr, input logic [31:0] data);
    int n;
    int m;
    @(posedge pcie_clk);
    axil_req.awaddr  <= {16'h0, addr};
    axil_req.wdata   <= data;
    axil_req.awvalid <= 1'b1;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= ($urandom % 4) != 0;
    n = 0;
    do begin
      @(posedge pcie_clk);
      n++;
    end while (!(awready && wready) && n < 50);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    if (n >= 50) report_timeout("awready and wready for a register write");
    m = 0;
    while (!(bvalid && axil_req.bready) && m < 50) begin
      axil_req.bready <= ($urandom % 4) != 0; // Random response back-pressure
      @(posedge pcie_clk);
      m++;
    end
    axil_req.bready <= 1'b0;
    if (m >= 50) report_timeout("write response bvalid");
  endtask

  // Optional status pulse lands in the acceptance cycle
  task automatic read_reg(input logic [`CSR_DEC_W-1:0] addr, input logic rd_pulse,
                          input logic wr_pulse, input logic [31:0] tag,
                          output logic [31:0] data);
    int n;
    int m;
    @(posedge pcie_clk);
    axil_req.araddr  <= {16'h0, addr};
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= ($urandom % 4) != 0;
    rd_status_tag    <= tag;
    wr_status_tag    <= tag;
    rd_status_valid  <= rd_pulse;
    wr_status_valid  <= wr_pulse;
    n = 0;
    do begin
      @(posedge pcie_clk);
      rd_status_valid <= 1'b0;
      wr_status_valid <= 1'b0;
      n++;
    end while (!arready && n < 50);
    axil_req.arvalid <= 1'b0;
    if (n >= 50) report_timeout("arready for a register read");
    m = 0;
    while (!(rvalid && axil_req.rready) && m < 50) begin
      axil_req.rready <= ($urandom % 4) != 0;
      @(posedge pcie_clk);
      m++;
    end
    data = rdata;
    axil_req.rready <= 1'b0;
    if (m >= 50) report_timeout("read data rvalid");
  endtask

  task automatic expect_read(input string name, input logic [`CSR_DEC_W-1:0] addr,
                             input logic [31:0] exp);
    logic [31:0] got;
    read_reg(addr, 1'b0, 1'b0, '0, got);
    check_value(name, exp, got);
  endtask

  task automatic pulse_status(input logic wr_side, input logic [31:0] tag);
    @(posedge pcie_clk);
    rd_status_tag   <= tag;
    wr_status_tag   <= tag;
    rd_status_valid <= !wr_side;
    wr_status_valid <= wr_side;
    @(posedge pcie_clk);
    rd_status_valid <= 1'b0;
    wr_status_valid <= 1'b0;
  endtask

  // Program all fields, then act as the DMA engine taking the descriptor
  task automatic launch_descriptor(input string name, input logic wr_side);
    pcie_cfg_pkg::dma_desc_t exp;
    pcie_cfg_pkg::dma_desc_t got;
    logic [`CSR_DEC_W-1:0]   base;
    int                      n;
    int                      hold;
    base = wr_side ? `REG_DMA_WR_BASE : `REG_DMA_RD_BASE;
    exp.pcie_addr = {$urandom, $urandom};
    exp.ram_addr  = $urandom;
    exp.len       = 16'($urandom);
    exp.tag       = $urandom;
    write_reg(base + `OFS_PCIE_LO, exp.pcie_addr[31:0]);
    write_reg(base + `OFS_PCIE_HI, exp.pcie_addr[63:32]);
    write_reg(base + `OFS_RAM, exp.ram_addr);
    write_reg(base + `OFS_LEN, {16'h0, exp.len});
    write_reg(base + `OFS_TAG, exp.tag);
    n = 0;
    while (!(wr_side ? wr_desc_valid : rd_desc_valid) && n < 50) begin
      @(posedge pcie_clk);
      n++;
    end
    if (n >= 50) report_timeout("descriptor valid");
    hold = $urandom_range(0, 5);
    repeat (hold) @(posedge pcie_clk);
    if (wr_side) wr_desc_ready <= 1'b1;
    else rd_desc_ready <= 1'b1;
    @(posedge pcie_clk);
    got = wr_side ? wr_desc : rd_desc;
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
    end
    rd_desc_ready <= 1'b0;
    wr_desc_ready <= 1'b0;
    @(posedge pcie_clk);
    check_value({name, "_single"}, 32'h0, {31'h0, wr_side ? wr_desc_valid : rd_desc_valid});
  endtask

  initial begin
    logic [31:0] got;
    logic [31:0] tags;
    logic [31:0] late;
    void'($urandom(32'hf9cd_de72));
    pcie_rst        = 1'b1;
    axil_req        = '0;
    rd_desc_ready   = 1'b0;
    wr_desc_ready   = 1'b0;
    rd_status_tag   = '0;
    wr_status_tag   = '0;
    rd_status_valid = 1'b0;
    wr_status_valid = 1'b0;
    checks          = 0;
    errors          = 0;
    timeouts        = 0;
    repeat (3) @(posedge pcie_clk);
    pcie_rst <= 1'b0;

    expect_read("fw_id", `REG_FW_ID, `FW_ID_VAL);
    expect_read("fw_ver", `REG_FW_VER, `FW_VER_VAL);
    expect_read("board_id", `REG_BOARD_ID, `BOARD_ID_VAL);
    expect_read("board_ver", `REG_BOARD_VER, `BOARD_VER_VAL);
    expect_read("fpga_id", `REG_FPGA_ID, `FPGA_ID_VAL);
    expect_read("dma_en_reset", `REG_DMA_EN, 32'h1);
    expect_read("loopback_reset", `REG_LOOPBACK, 32'h0);
    expect_read("unmapped", 16'h0100, 32'h0);

    write_reg(`REG_DMA_EN, 32'h0);
    check_value("dma_enable_o", 32'h0, {31'h0, dma_enable});
    expect_read("dma_en_readback", `REG_DMA_EN, 32'h0);
    write_reg(`REG_LOOPBACK, 32'h1);
    check_value("loopback_o", 32'h1, {31'h0, loopback});
    expect_read("loopback_readback", `REG_LOOPBACK, 32'h1);
    write_reg(`REG_DMA_EN, 32'h1);

    launch_descriptor("rd_desc", 1'b0);
    launch_descriptor("wr_desc", 1'b1);

    for (int ch = 0; ch < 2; ch++) begin
      tags = '0;
      repeat (1 + $urandom_range(0, 5)) begin
        late = $urandom;
        pulse_status(ch == 1, late);
        tags = tags | late;
      end
      read_reg(status_addr(ch == 1), 1'b0, 1'b0, '0, got);
      check_value(ch == 1 ? "wr_status_or" : "rd_status_or", tags, got);
      expect_read(ch == 1 ? "wr_status_clear" : "rd_status_clear", status_addr(ch == 1), 32'h0);

      // Disjoint halves so the late tag is clearly absent from the first read
      tags = ($urandom & 32'h0000_ffff) | 32'h1;
      late = ($urandom & 32'hffff_0000) | 32'h1_0000;
      pulse_status(ch == 1, tags);
      read_reg(status_addr(ch == 1), ch == 0, ch == 1, late, got);
      check_value(ch == 1 ? "wr_status_early" : "rd_status_early", tags, got);
      expect_read(ch == 1 ? "wr_status_late" : "rd_status_late", status_addr(ch == 1), late);
    end

    repeat (20) begin
      late = {31'h0, ($urandom % 2) == 1};
      write_reg(`REG_LOOPBACK, late);
      expect_read("loopback_b2b", `REG_LOOPBACK, late);
    end

    repeat (2) @(posedge pcie_clk);
    $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, dut.u_props.fail_count);
    if (errors == 0 && timeouts == 0 && dut.u_props.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+common
common/pcie_cfg_pkg.sv
dma_desc/dma_desc_channel.sv
src/pcie_cfg_csr.sv
src/pcie_cfg_top.sv
bench/pcie_cfg_props.sv
bench/pcie_cfg_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pcie_cfg_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
SRCS      ?= $(filter-out +incdir+%,$(shell cat $(FILELIST)))
INCDIRS   ?= $(patsubst +incdir+%,%,$(filter +incdir+%,$(shell cat $(FILELIST))))
HDRS      ?= $(foreach d,$(INCDIRS),$(wildcard $(d)/*.svh))
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)
